// File: Bender.yml
package:
  name: lookahead_router

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/noc_pkg.sv
      - hw/input_queue.sv
      - hw/xy_lookahead.sv
      - hw/input_unit.sv
      - hw/output_arbiter.sv
      - hw/output_unit.sv
      - hw/lookahead_router.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/router_tb.sv

// File: hw/input_queue.sv
////////////////////////////////////////
// Bypassable input FIFO
// Shows the incoming flit when empty
////////////////////////////////////////

`timescale 1ns/1ps

`include "noc_defines.svh"

module input_queue (
  input  logic           clk,
  input  logic           rst,
  input  logic           wr_i,
  input  noc_pkg::flit_t data_i,
  input  logic           data_void_i,
  input  logic           rd_i,
  output noc_pkg::flit_t head_o,
  output logic           empty_o,
  output logic           full_o
);

  localparam int unsigned depth     = `NOC_QUEUE_DEPTH;
  localparam int unsigned ptr_width = $clog2(depth);
  localparam int unsigned cnt_width = $clog2(depth + 1);

  noc_pkg::flit_t        mem [depth];
  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;
  logic [cnt_width-1:0]  count;
  logic                  is_empty;
  logic                  bypass;
  logic                  push;
  logic                  pop;

  assign is_empty = count == '0;
  assign full_o   = count == cnt_width'(depth);

  // Flit passes straight through, never stored
  assign bypass = is_empty & wr_i & rd_i;
  assign push   = wr_i & ~full_o & ~bypass;
  // Reads on an empty queue are dropped
  assign pop    = rd_i & ~is_empty;

  assign head_o  = is_empty ? data_i : mem[rd_ptr];
  // Nothing stored and nothing arriving
  assign empty_o = is_empty & data_void_i;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy only moves on an unbalanced cycle
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: hw/input_unit.sv
////////////////////////////////////////
// Router input port
// Queue, saved request, stop level and
// look-ahead routing of the queue head
////////////////////////////////////////

`timescale 1ns/1ps

`include "noc_defines.svh"

module input_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  noc_pkg::xy_t               position_i,
  input  noc_pkg::flit_t             data_i,
  input  logic                       data_void_i,
  input  logic [`NOC_NUM_PORTS-1:0]  rd_i,
  output logic                       stop_o,
  output noc_pkg::in_view_t          view_o
);

  noc_pkg::flit_t  head;
  noc_pkg::route_t saved_request;
  noc_pkg::route_t next_route;
  logic            wr;
  logic            rd_any;
  logic            empty;
  logic            full;
  logic            valid;
  logic            valid_head;

  // Any output may pop this queue
  assign rd_any = |rd_i;
  assign wr     = ~data_void_i;

  input_queue u_queue (
    .clk         (clk),
    .rst         (rst),
    .wr_i        (wr),
    .data_i      (data_i),
    .data_void_i (data_void_i),
    .rd_i        (rd_any),
    .head_o      (head),
    .empty_o     (empty),
    .full_o      (full)
  );

  // Refuse flits once the queue is full
  assign stop_o = full;

  assign valid      = ~empty;
  assign valid_head = valid & head.header.preamble.head;

  // Worm keeps asking for the same output
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_request <= '0;
    end else if (valid && head.header.preamble.tail) begin
      // Tail at the head ends the worm
      saved_request <= '0;
    end else if (valid_head) begin
      saved_request <= head.header.route;
    end
  end

  xy_lookahead u_lookahead (
    .position_i   (position_i),
    .dest_i       (head.header.dest),
    .route_i      (head.header.route),
    .next_route_o (next_route)
  );

  always_comb begin
    view_o.head       = head;
    view_o.valid      = valid;
    // Live route field on a head, saved one inside a worm
    view_o.request    = valid_head ? head.header.route : saved_request;
    view_o.next_route = next_route;
  end

endmodule

// File: hw/lookahead_router.sv
////////////////////////////////////////
// Five-port look-ahead mesh router
// Input units, output units and the read
// vector transpose between them
////////////////////////////////////////

`timescale 1ns/1ps

`include "noc_defines.svh"

module lookahead_router (
  input  logic                                   clk,
  input  logic                                   rst,
  input  noc_pkg::xy_t                           position_i,
  input  noc_pkg::flit_t [`NOC_NUM_PORTS-1:0]    data_i,
  input  logic [`NOC_NUM_PORTS-1:0]              data_void_i,
  output logic [`NOC_NUM_PORTS-1:0]              stop_o,
  output noc_pkg::flit_t [`NOC_NUM_PORTS-1:0]    data_o,
  output logic [`NOC_NUM_PORTS-1:0]              data_void_o,
  input  logic [`NOC_NUM_PORTS-1:0]              stop_i
);

  localparam int unsigned num_ports = `NOC_NUM_PORTS;

  // Every output sees every input
  noc_pkg::in_view_t [num_ports-1:0] views;

  // Indexed output then input
  logic [num_ports-1:0][num_ports-1:0] rd_out;
  // Indexed input then output
  wire  [num_ports-1:0][num_ports-1:0] rd_in;

  for (genvar o = 0; o < num_ports; o++) begin : gen_rd_row
    for (genvar i = 0; i < num_ports; i++) begin : gen_rd_col
      assign rd_in[i][o] = rd_out[o][i];
    end
  end

  ////////////////////////////////////////
  // One input and one output per port
  ////////////////////////////////////////

  for (genvar p = 0; p < num_ports; p++) begin : gen_port

    input_unit u_input (
      .clk         (clk),
      .rst         (rst),
      .position_i  (position_i),
      .data_i      (data_i[p]),
      .data_void_i (data_void_i[p]),
      .rd_i        (rd_in[p]),
      .stop_o      (stop_o[p]),
      .view_o      (views[p])
    );

    output_unit #(
      .out_port (noc_pkg::port_e'(p))
    ) u_output (
      .clk         (clk),
      .rst         (rst),
      .views_i     (views),
      .stop_i      (stop_i[p]),
      .rd_o        (rd_out[p]),
      .data_o      (data_o[p]),
      .data_void_o (data_void_o[p])
    );

  end

endmodule

// File: hw/noc_defines.svh
////////////////////////////////////////
// Router sizing macros
// Flit width without preamble, port count,
// input queue depth, coordinate width
////////////////////////////////////////

`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Flit payload width, preamble bits not counted
`define NOC_DATA_WIDTH 32

// North, south, west, east and local
`define NOC_NUM_PORTS 5

// Entries per input queue
`define NOC_QUEUE_DEPTH 4

// Bits per mesh coordinate
`define NOC_COORD_WIDTH 3

`endif

// File: hw/noc_pkg.sv
////////////////////////////////////////
// Router package
// Port, route, coordinate and flit types
// Input view and output state types
////////////////////////////////////////

`include "noc_defines.svh"

package noc_pkg;

  // Port index, also the bit position in a route
  typedef enum logic [2:0] {
    port_north = 3'd0,
    port_south = 3'd1,
    port_west  = 3'd2,
    port_east  = 3'd3,
    port_local = 3'd4
  } port_e;

  // One-hot output choice, all zero for none
  typedef logic [`NOC_NUM_PORTS-1:0] route_t;

  typedef struct packed {
    logic [`NOC_COORD_WIDTH-1:0] x;
    logic [`NOC_COORD_WIDTH-1:0] y;
  } xy_t;

  // Message opcode, carried through untouched
  typedef enum logic [4:0] {
    msg_request   = 5'd0,
    msg_response  = 5'd1,
    msg_interrupt = 5'd2
  } msg_e;

  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  localparam int unsigned reserved_width =
    `NOC_DATA_WIDTH - 2 * $bits(xy_t) - $bits(msg_e) - $bits(route_t);
  localparam int unsigned flit_width = `NOC_DATA_WIDTH + $bits(preamble_t);

  // Route field sits in the low bits
  typedef struct packed {
    preamble_t                 preamble;
    xy_t                       source;
    xy_t                       dest;
    msg_e                      msg;
    logic [reserved_width-1:0] reserved;
    route_t                    route;
  } header_t;

  // Body flits use the raw word
  typedef union packed {
    header_t                 header;
    logic [flit_width-1:0]   raw;
  } flit_t;

  // What an output unit sees of one input
  typedef struct packed {
    flit_t  head;
    logic   valid;
    route_t request;
    route_t next_route;
  } in_view_t;

  typedef enum logic {
    out_head    = 1'b0,
    out_payload = 1'b1
  } out_state_e;

endpackage

// File: hw/output_arbiter.sv
////////////////////////////////////////
// Rotating-priority arbiter
// Four contenders for one output
////////////////////////////////////////

`timescale 1ns/1ps

module output_arbiter (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] req_i,
  input  logic       head_fwd_i,
  input  logic       tail_fwd_i,
  output logic [3:0] grant_o,
  output logic       grant_valid_o
);

  logic [1:0] pointer;
  logic [1:0] grant_idx;
  logic [1:0] owner_idx;

  // First requester at or after the pointer
  always_comb begin : pick
    logic [1:0] idx;
    logic       found;
    grant_o   = '0;
    grant_idx = pointer;
    found     = 1'b0;
    for (int i = 0; i < 4; i++) begin
      idx = pointer + 2'(i);
      if (!found && req_i[idx]) begin
        grant_o[idx] = 1'b1;
        grant_idx    = idx;
        found        = 1'b1;
      end
    end
    grant_valid_o = found;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pointer   <= '0;
      owner_idx <= '0;
    end else begin
      // Worm owner, fixed when its head leaves
      if (head_fwd_i) begin
        owner_idx <= grant_idx;
      end
      // Move past the finished worm
      if (tail_fwd_i) begin
        pointer <= (head_fwd_i ? grant_idx : owner_idx) + 2'd1;
      end
    end
  end

endmodule

// File: hw/output_unit.sv
////////////////////////////////////////
// Router output port
// Worm FSM, crossbar select, route field
// insertion and output register
////////////////////////////////////////

`timescale 1ns/1ps

`include "noc_defines.svh"

module output_unit #(
  parameter noc_pkg::port_e out_port = noc_pkg::port_north
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  noc_pkg::in_view_t [`NOC_NUM_PORTS-1:0]   views_i,
  input  logic                                     stop_i,
  output logic [`NOC_NUM_PORTS-1:0]                rd_o,
  output noc_pkg::flit_t                           data_o,
  output logic                                     data_void_o
);

  localparam int unsigned num_ports = `NOC_NUM_PORTS;

  noc_pkg::out_state_e     state;
  noc_pkg::out_state_e     next_state;
  logic [num_ports-2:0]    req;
  logic [num_ports-2:0]    grant;
  logic                    grant_valid;
  logic [num_ports-1:0]    grant_sel;
  logic [num_ports-1:0]    sel;
  logic [num_ports-1:0]    sel_saved;
  noc_pkg::flit_t          xbar_flit;
  noc_pkg::route_t         xbar_next;
  logic                    xbar_valid;
  logic                    forward;
  logic                    head_fwd;
  logic                    tail_fwd;
  logic                    first_flit;
  noc_pkg::flit_t          out_flit;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  // Requests from the other four inputs, own port skipped
  always_comb begin : gather
    int in_idx;
    req = '0;
    for (int k = 0; k < num_ports - 1; k++) begin
      in_idx = (k < int'(out_port)) ? k : k + 1;
      req[k] = views_i[in_idx].request[out_port];
    end
  end

  // Grant back in input numbering
  always_comb begin : scatter
    int in_idx;
    grant_sel = '0;
    for (int k = 0; k < num_ports - 1; k++) begin
      in_idx = (k < int'(out_port)) ? k : k + 1;
      grant_sel[in_idx] = grant[k];
    end
  end

  output_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .req_i         (req),
    .head_fwd_i    (head_fwd),
    .tail_fwd_i    (tail_fwd),
    .grant_o       (grant),
    .grant_valid_o (grant_valid)
  );

  ////////////////////////////////////////
  // Worm FSM and crossbar
  ////////////////////////////////////////

  // Input feeding this output this cycle
  always_comb begin
    sel = '0;
    case (state)
      noc_pkg::out_head: begin
        if (grant_valid && !stop_i) begin
          sel = grant_sel;
        end
      end
      noc_pkg::out_payload: sel = sel_saved;
      default: sel = '0;
    endcase
  end

  // One-hot select over the five views
  always_comb begin
    xbar_flit  = '0;
    xbar_next  = '0;
    xbar_valid = 1'b0;
    for (int i = 0; i < num_ports; i++) begin
      if (sel[i]) begin
        xbar_flit  = views_i[i].head;
        xbar_next  = views_i[i].next_route;
        xbar_valid = views_i[i].valid;
      end
    end
  end

  assign forward  = xbar_valid & ~stop_i;
  assign head_fwd = forward & xbar_flit.header.preamble.head;
  assign tail_fwd = forward & xbar_flit.header.preamble.tail;

  // Pop only the selected input, nothing under stop
  assign rd_o = stop_i ? '0 : sel;

  always_comb begin
    next_state = state;
    case (state)
      noc_pkg::out_head: begin
        // Single-flit worms stay in head state
        if (head_fwd && !tail_fwd) begin
          next_state = noc_pkg::out_payload;
        end
      end
      noc_pkg::out_payload: begin
        if (tail_fwd) begin
          next_state = noc_pkg::out_head;
        end
      end
      default: next_state = noc_pkg::out_head;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= noc_pkg::out_head;
      sel_saved  <= '0;
      first_flit <= 1'b1;
    end else begin
      state <= next_state;
      // Hold the input for the rest of the worm
      if (head_fwd) begin
        sel_saved <= sel;
      end
      if (tail_fwd) begin
        first_flit <= 1'b1;
      end else if (head_fwd) begin
        first_flit <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Route insertion and output register
  ////////////////////////////////////////

  // Head carries the neighbor's output
  always_comb begin
    out_flit = xbar_flit;
    if (first_flit) begin
      out_flit.header.route = xbar_next;
    end
  end

  always_ff @(posedge clk) begin
    if (forward) begin
      data_o <= out_flit;
    end
  end

  // Void level holds with the data under stop
  always_ff @(posedge clk) begin
    if (rst) begin
      data_void_o <= 1'b1;
    end else if (!stop_i) begin
      data_void_o <= ~forward;
    end
  end

endmodule

// File: hw/xy_lookahead.sv
////////////////////////////////////////
// Look-ahead XY routing
// Output the next router will take
////////////////////////////////////////

`timescale 1ns/1ps

module xy_lookahead (
  input  noc_pkg::xy_t    position_i,
  input  noc_pkg::xy_t    dest_i,
  input  noc_pkg::route_t route_i,
  output noc_pkg::route_t next_route_o
);

  noc_pkg::xy_t next_pos;

  // Neighbor reached through the chosen output
  always_comb begin
    next_pos = position_i;
    if (route_i[noc_pkg::port_north]) begin
      next_pos.y = position_i.y - 1'b1;
    end else if (route_i[noc_pkg::port_south]) begin
      next_pos.y = position_i.y + 1'b1;
    end else if (route_i[noc_pkg::port_west]) begin
      next_pos.x = position_i.x - 1'b1;
    end else if (route_i[noc_pkg::port_east]) begin
      next_pos.x = position_i.x + 1'b1;
    end
  end

  // XY order at the neighbor, x first then y
  always_comb begin
    next_route_o = '0;
    if (route_i == '0) begin
      // No request, no next hop
      next_route_o = '0;
    end else if (route_i[noc_pkg::port_local]) begin
      next_route_o[noc_pkg::port_local] = 1'b1;
    end else if (next_pos.x != dest_i.x) begin
      if (dest_i.x > next_pos.x) begin
        next_route_o[noc_pkg::port_east] = 1'b1;
      end else begin
        next_route_o[noc_pkg::port_west] = 1'b1;
      end
    end else if (next_pos.y != dest_i.y) begin
      if (dest_i.y > next_pos.y) begin
        next_route_o[noc_pkg::port_south] = 1'b1;
      end else begin
        next_route_o[noc_pkg::port_north] = 1'b1;
      end
    end else begin
      next_route_o[noc_pkg::port_local] = 1'b1;
    end
  end

endmodule

// File: tb.f
+incdir+hw
hw/noc_pkg.sv
hw/input_queue.sv
hw/xy_lookahead.sv
hw/input_unit.sv
hw/output_arbiter.sv
hw/output_unit.sv
hw/lookahead_router.sv
test/router_tb.sv

// File: test/router_tb.sv
////////////////////////////////////////
// Router testbench
// Clock, reset, worm stimulus, expected
// flit queues and output assertions
////////////////////////////////////////

`timescale 1ns/1ps

`include "noc_defines.svh"

module router_tb;

  localparam int num_ports      = `NOC_NUM_PORTS;
  localparam int timeout_cycles = 200;
  localparam int router_x       = 2;
  localparam int router_y       = 2;

  // Conditions a wait loop can stop on
  localparam int wait_drained = 0;
  localparam int wait_valid   = 1;
  localparam int wait_stopped = 2;

  logic                            clk;
  logic                            rst;
  noc_pkg::xy_t                    position_i;
  noc_pkg::flit_t [num_ports-1:0]  data_i;
  logic [num_ports-1:0]            data_void_i;
  logic [num_ports-1:0]            stop_o;
  noc_pkg::flit_t [num_ports-1:0]  data_o;
  logic [num_ports-1:0]            data_void_o;
  logic [num_ports-1:0]            stop_i;

  logic [31:0]    lfsr_state;
  // Expected flits, indexed output * num_ports + input
  noc_pkg::flit_t exp_q [num_ports*num_ports][$];
  // Input owning each output's open worm, -1 when idle
  int             worm_src [num_ports];

  lookahead_router u_dut (
    .clk         (clk),
    .rst         (rst),
    .position_i  (position_i),
    .data_i      (data_i),
    .data_void_i (data_void_i),
    .stop_o      (stop_o),
    .data_o      (data_o),
    .data_void_o (data_void_o),
    .stop_i      (stop_i)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
      r[i] = lfsr_state[0];
    end
    return r;
  endfunction

  function automatic noc_pkg::route_t one_hot(input int port);
    noc_pkg::route_t r;
    r       = '0;
    r[port] = 1'b1;
    return r;
  endfunction

  function automatic noc_pkg::xy_t make_xy(input int x, input int y);
    noc_pkg::xy_t r;
    r.x = x[`NOC_COORD_WIDTH-1:0];
    r.y = y[`NOC_COORD_WIDTH-1:0];
    return r;
  endfunction

  // XY rule applied at the neighbor behind out_port
  function automatic noc_pkg::route_t expect_next_route(input int out_port,
                                                        input noc_pkg::xy_t dest);
    int              x;
    int              y;
    noc_pkg::route_t r;
    x = router_x;
    y = router_y;
    r = one_hot(4);
    // North, south, west, east; local stays local
    case (out_port)
      0: y = y - 1;
      1: y = y + 1;
      2: x = x - 1;
      3: x = x + 1;
      default: return r;
    endcase
    if (int'(dest.x) > x) begin
      r = one_hot(3);
    end else if (int'(dest.x) < x) begin
      r = one_hot(2);
    end else if (int'(dest.y) > y) begin
      r = one_hot(1);
    end else if (int'(dest.y) < y) begin
      r = one_hot(0);
    end
    return r;
  endfunction

  function automatic int pending_flits();
    int total;
    total = 0;
    for (int i = 0; i < num_ports * num_ports; i++) begin
      total += exp_q[i].size();
    end
    return total;
  endfunction

  function automatic logic reached(input int kind, input int port);
    case (kind)
      wait_valid:   return data_void_o[port] == 1'b0;
      wait_stopped: return stop_o[port] == 1'b1;
      default:      return pending_flits() == 0;
    endcase
  endfunction

  // Sampled on falling edges, where outputs are settled
  task automatic wait_until(input int kind, input int port, input int limit,
                            input string what);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      assert (reached(kind, port) || waited < limit) else fail_run(what);
    end while (!reached(kind, port));
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Called on a rising edge, returns on the edge that took the flit
  task automatic drive_flit(input int port, input noc_pkg::flit_t f);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    data_i[port]      <= f;
    data_void_i[port] <= 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = !stop_o[port];
      waited++;
      assert (taken || waited < timeout_cycles)
        else fail_run($sformatf("input %0d refused a flit for too long", port));
      @(posedge clk);
    end
  endtask

  task automatic send_worm(input int in_port, input int out_port,
                           input noc_pkg::xy_t dest, input int len);
    noc_pkg::flit_t worm [$];
    noc_pkg::flit_t f;
    logic [31:0]    rnd;
    int             idx;
    idx = out_port * num_ports + in_port;
    rnd = next_bits(6 + noc_pkg::reserved_width);
    f   = '0;
    f.header.preamble.head = 1'b1;
    f.header.preamble.tail = (len == 1);
    f.header.source        = rnd[5:0];
    f.header.dest          = dest;
    f.header.msg           = noc_pkg::msg_request;
    f.header.reserved      = rnd[noc_pkg::reserved_width+5:6];
    f.header.route         = one_hot(out_port);
    worm.push_back(f);
    // Head leaves with the neighbor's output in its route field
    f.header.route = expect_next_route(out_port, dest);
    exp_q[idx].push_back(f);
    // Body and tail pass untouched
    for (int n = 1; n < len; n++) begin
      f                      = '0;
      f.raw[31:0]            = next_bits(32);
      f.header.preamble.tail = (n == len - 1);
      worm.push_back(f);
      exp_q[idx].push_back(f);
    end
    @(posedge clk);
    foreach (worm[n]) begin
      drive_flit(in_port, worm[n]);
    end
    data_void_i[in_port] <= 1'b1;
  endtask

  task automatic deliver_alone(input int in_port, input int out_port,
                               input noc_pkg::xy_t dest, input int len);
    send_worm(in_port, out_port, dest, len);
    wait_until(wait_drained, 0, timeout_cycles, "a worm was not delivered in time");
  endtask

  ////////////////////////////////////////
  // Output checking
  ////////////////////////////////////////

  // A head opens a worm from one input, later flits must follow from it
  task automatic take_output_flit(input int o, input noc_pkg::flit_t f);
    int src;
    int idx;
    src = worm_src[o];
    if (src < 0) begin
      for (int i = 0; i < num_ports; i++) begin
        idx = o * num_ports + i;
        if (src < 0 && exp_q[idx].size() > 0 && exp_q[idx][0] == f) begin
          src = i;
        end
      end
      assert (src >= 0)
        else fail_run($sformatf("[FAIL] data_o[%0d] = %h matches no waiting worm", o, f.raw));
    end
    idx = o * num_ports + src;
    assert (exp_q[idx][0] == f)
      else fail_run($sformatf("[FAIL] data_o[%0d] got %h expected %h",
                              o, f.raw, exp_q[idx][0].raw));
    exp_q[idx].pop_front();
    worm_src[o] = f.header.preamble.tail ? -1 : src;
  endtask

  // Neighbor takes a flit where void and stop are both low
  always @(negedge clk) begin
    if (!rst) begin
      for (int o = 0; o < num_ports; o++) begin
        if (data_void_o[o] == 1'b0 && stop_i[o] == 1'b0) begin
          take_output_flit(o, data_o[o]);
        end
      end
    end
  end

  // Data and void level hold while the neighbor stops the output
  for (genvar p = 0; p < num_ports; p++) begin : gen_hold_check
    assert property (@(posedge clk) disable iff (rst)
      stop_i[p] |=> data_void_o[p] == $past(data_void_o[p]) &&
                    (data_void_o[p] || data_o[p] == $past(data_o[p])))
      else fail_run($sformatf("[FAIL] data_o[%0d] = %h data_void_o[%0d] = %h moved under stop_i",
                              p, data_o[p].raw, p, data_void_o[p]));
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    position_i  = make_xy(router_x, router_y);
    data_i      = '0;
    data_void_i = '1;
    stop_i      = '0;
    lfsr_state  = 32'hdf05_d9ce;
    for (int o = 0; o < num_ports; o++) begin
      worm_src[o] = -1;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Idle router after reset
    repeat (3) begin
      @(negedge clk);
      assert (data_void_o == '1)
        else fail_run($sformatf("[FAIL] data_void_o got %h expected %h",
                                data_void_o, {num_ports{1'b1}}));
      assert (stop_o == '0)
        else fail_run($sformatf("[FAIL] stop_o got %h expected %h", stop_o, 5'h00));
    end

    // Single flit, local to east, free output
    send_worm(noc_pkg::port_local, noc_pkg::port_east, make_xy(5, 2), 1);
    wait_until(wait_valid, noc_pkg::port_east, 2, "single flit was late on the east output");
    wait_until(wait_drained, 0, timeout_cycles, "single flit was not delivered");

    // Worms in every direction, one hop ones end in local
    deliver_alone(noc_pkg::port_local, noc_pkg::port_north, make_xy(2, 0), 5);
    deliver_alone(noc_pkg::port_local, noc_pkg::port_south, make_xy(2, 5), 4);
    deliver_alone(noc_pkg::port_local, noc_pkg::port_west, make_xy(1, 2), 3);
    deliver_alone(noc_pkg::port_local, noc_pkg::port_east, make_xy(3, 2), 6);
    deliver_alone(noc_pkg::port_north, noc_pkg::port_local, make_xy(2, 2), 4);
    deliver_alone(noc_pkg::port_west, noc_pkg::port_east, make_xy(6, 3), 5);
    deliver_alone(noc_pkg::port_east, noc_pkg::port_west, make_xy(0, 1), 3);
    deliver_alone(noc_pkg::port_north, noc_pkg::port_south, make_xy(2, 4), 4);
    deliver_alone(noc_pkg::port_south, noc_pkg::port_north, make_xy(4, 0), 2);

    // Two, then three worms racing for one output
    fork
      send_worm(noc_pkg::port_local, noc_pkg::port_east, make_xy(6, 2), 6);
      send_worm(noc_pkg::port_north, noc_pkg::port_east, make_xy(5, 1), 6);
    join
    wait_until(wait_drained, 0, timeout_cycles, "contending worms to east were not delivered");
    fork
      send_worm(noc_pkg::port_north, noc_pkg::port_local, make_xy(2, 2), 4);
      send_worm(noc_pkg::port_south, noc_pkg::port_local, make_xy(2, 2), 3);
      send_worm(noc_pkg::port_west, noc_pkg::port_local, make_xy(2, 2), 5);
    join
    wait_until(wait_drained, 0, timeout_cycles, "contending worms to local were not delivered");

    // Stop the north output mid worm until the local queue fills
    fork
      send_worm(noc_pkg::port_local, noc_pkg::port_north, make_xy(2, 0), 10);
      begin
        wait_until(wait_valid, noc_pkg::port_north, timeout_cycles,
                   "worm never reached the north output");
        @(posedge clk);
        stop_i[noc_pkg::port_north] <= 1'b1;
        wait_until(wait_stopped, noc_pkg::port_local, timeout_cycles,
                   "local input never refused flits while north was stopped");
        repeat (4) @(posedge clk);
        stop_i[noc_pkg::port_north] <= 1'b0;
      end
    join
    wait_until(wait_drained, 0, timeout_cycles, "flits were lost after back-pressure");

    // Quiet tail so a late duplicate still gets caught, queues end empty
    repeat (5) @(posedge clk);
    if (stop_o == '0) begin
      $display("** PASS **");
      $finish;
    end else begin
      fail_run($sformatf("[FAIL] stop_o got %h expected %h", stop_o, 5'h00));
    end
  end

endmodule
